// ==== source/aes_types_pkg.sv ====
package aes_types_pkg;

        // Round count for a 128-bit key
        localparam int rounds_default = 10;

        typedef logic [7:0] byte_t;

        // One state column, first byte in the top bits
        typedef logic [31:0] word_t;

        // Byte 0 in bits 127:120, then column by column
        typedef logic [127:0] block_t;

        // Wide enough for 0 to 15
        typedef logic [3:0] round_idx_t;

        typedef struct packed {
                block_t cipher_text;
                block_t cipher_key;
        } inv_job_t;

endpackage

// ==== source/aes_field_pkg.sv ====
package aes_field_pkg;

        // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
        function automatic aes_types_pkg::byte_t xtime(input aes_types_pkg::byte_t b);
                return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        endfunction

        // Shift and add over the bits of b
        function automatic aes_types_pkg::byte_t gf_mul(input aes_types_pkg::byte_t a,
                                                        input aes_types_pkg::byte_t b);
                aes_types_pkg::byte_t acc;
                aes_types_pkg::byte_t term;
                acc = '0;
                term = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i])
                                acc ^= term;
                        term = xtime(term);
                end
                return acc;
        endfunction

        // a^254, so zero maps to zero
        function automatic aes_types_pkg::byte_t gf_inverse(input aes_types_pkg::byte_t a);
                aes_types_pkg::byte_t result;
                aes_types_pkg::byte_t power;
                result = 8'h01;
                power = a;
                for (int k = 1; k < 8; k++) begin
                        power = gf_mul(power, power); // a^(2^k)
                        result = gf_mul(result, power);
                end
                return result;
        endfunction

        function automatic aes_types_pkg::byte_t rotl(input aes_types_pkg::byte_t b,
                                                      input int n);
                return (b << n) | (b >> (8 - n));
        endfunction

        function automatic aes_types_pkg::byte_t sbox_forward(input aes_types_pkg::byte_t b);
                aes_types_pkg::byte_t inv;
                inv = gf_inverse(b);
                return inv ^ rotl(inv, 1) ^ rotl(inv, 2) ^ rotl(inv, 3) ^ rotl(inv, 4) ^ 8'h63;
        endfunction

        function automatic aes_types_pkg::byte_t sbox_inverse(input aes_types_pkg::byte_t b);
                aes_types_pkg::byte_t pre;
                pre = rotl(b, 1) ^ rotl(b, 3) ^ rotl(b, 6) ^ 8'h05; // Undo the affine step
                return gf_inverse(pre);
        endfunction

endpackage

// ==== source/byte_substitute.sv ====
module byte_substitute #(
        parameter type payload_t = aes_types_pkg::word_t,
        parameter bit INVERSE = 1'b0
) (
        input payload_t in_bytes,
        output payload_t out_bytes
);

        localparam int num_bytes = $bits(payload_t) / 8;

        always_comb begin
                for (int i = 0; i < num_bytes; i++) begin
                        if (INVERSE)
                                out_bytes[8*i +: 8] = aes_field_pkg::sbox_inverse(in_bytes[8*i +: 8]);
                        else
                                out_bytes[8*i +: 8] = aes_field_pkg::sbox_forward(in_bytes[8*i +: 8]);
                end
        end

endmodule

// ==== source/key_expander.sv ====
module key_expander #(
        parameter int ROUNDS = aes_types_pkg::rounds_default
) (
        input logic clk,
        input logic rst,
        input logic key_req,
        input aes_types_pkg::block_t cipher_key,
        output logic key_ack,
        input aes_types_pkg::round_idx_t key_sel,
        output aes_types_pkg::block_t round_key
);

        aes_types_pkg::block_t round_keys [ROUNDS+1];
        aes_types_pkg::block_t last_key;
        aes_types_pkg::block_t next_key;
        aes_types_pkg::word_t rot_word;
        aes_types_pkg::word_t sub_word;
        aes_types_pkg::word_t mix_word;
        aes_types_pkg::word_t next_w0;
        aes_types_pkg::word_t next_w1;
        aes_types_pkg::word_t next_w2;
        aes_types_pkg::word_t next_w3;
        aes_types_pkg::byte_t rcon;
        aes_types_pkg::round_idx_t key_idx;
        logic expanding;
        logic load;

        assign load = key_req && !expanding && !key_ack; // New request only

        assign rot_word = {last_key[23:0], last_key[31:24]}; // RotWord of last column

        byte_substitute #(
                .payload_t(aes_types_pkg::word_t),
                .INVERSE(1'b0)
        ) i_sub_word (
                .in_bytes(rot_word),
                .out_bytes(sub_word)
        );

        assign mix_word = sub_word ^ {rcon, 24'h000000};

        assign next_w0 = last_key[127:96] ^ mix_word;
        assign next_w1 = last_key[95:64] ^ next_w0;
        assign next_w2 = last_key[63:32] ^ next_w1;
        assign next_w3 = last_key[31:0] ^ next_w2;
        assign next_key = {next_w0, next_w1, next_w2, next_w3};

        always_ff @(posedge clk) begin
                if (rst) begin
                        expanding <= 1'b0;
                        key_ack <= 1'b0;
                        key_idx <= '0;
                end else if (load) begin
                        expanding <= 1'b1;
                        key_idx <= aes_types_pkg::round_idx_t'(1);
                end else if (expanding) begin
                        key_idx <= key_idx + 1'b1;
                        if (key_idx == aes_types_pkg::round_idx_t'(ROUNDS)) begin
                                expanding <= 1'b0; // Last key written this cycle
                                key_ack <= 1'b1;
                        end
                end else if (key_ack && !key_req) begin
                        key_ack <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        round_keys[0] <= cipher_key;
                        last_key <= cipher_key;
                        rcon <= 8'h01;
                end else if (expanding) begin
                        round_keys[key_idx] <= next_key;
                        last_key <= next_key;
                        rcon <= aes_field_pkg::xtime(rcon);
                end
        end

        assign round_key = round_keys[key_sel];

endmodule

// ==== source/inv_round.sv ====
module inv_round (
        input aes_types_pkg::block_t state_in,
        input aes_types_pkg::block_t round_key,
        input logic mix_enable,
        output aes_types_pkg::block_t state_out
);

        localparam aes_types_pkg::byte_t mix_coef [4] = '{8'h0e, 8'h0b, 8'h0d, 8'h09};

        aes_types_pkg::block_t shifted;
        aes_types_pkg::block_t subbed;
        aes_types_pkg::block_t added;
        aes_types_pkg::block_t mixed;

        // Row r moves right by r columns
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                shifted[127 - 8*(4*c + r) -: 8] =
                                        state_in[127 - 8*(4*((c - r + 4) % 4) + r) -: 8];
                        end
                end
        end

        byte_substitute #(
                .payload_t(aes_types_pkg::block_t),
                .INVERSE(1'b1)
        ) i_inv_sub_bytes (
                .in_bytes(shifted),
                .out_bytes(subbed)
        );

        assign added = subbed ^ round_key;

        // Each output byte takes the coefficient row rotated by its row index
        always_comb begin
                aes_types_pkg::byte_t acc;
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                acc = '0;
                                for (int k = 0; k < 4; k++) begin
                                        acc ^= aes_field_pkg::gf_mul(mix_coef[(k - r + 4) % 4],
                                                added[127 - 8*(4*c + k) -: 8]);
                                end
                                mixed[127 - 8*(4*c + r) -: 8] = acc;
                        end
                end
        end

        assign state_out = mix_enable ? mixed : added; // No InvMixColumns in the last round

endmodule

// ==== source/inv_cipher_ctrl.sv ====
module inv_cipher_ctrl #(
        parameter int ROUNDS = aes_types_pkg::rounds_default
) (
        input logic clk,
        input logic rst,
        input logic start,
        input aes_types_pkg::inv_job_t job,
        output logic done,
        output aes_types_pkg::block_t plain_text,
        output logic key_req,
        output aes_types_pkg::block_t cipher_key,
        input logic key_ack,
        output aes_types_pkg::round_idx_t key_sel,
        input aes_types_pkg::block_t round_key,
        output aes_types_pkg::block_t round_state,
        output logic mix_enable,
        input aes_types_pkg::block_t next_state
);

        typedef enum logic [2:0] {
                idle,
                expand,
                init_add,
                run_rounds,
                finish,
                key_release
        } ctrl_state_t;

        ctrl_state_t fsm_q;
        ctrl_state_t fsm_d;
        aes_types_pkg::round_idx_t round_cnt;
        aes_types_pkg::block_t state_q;

        always_comb begin
                fsm_d = fsm_q;
                case (fsm_q)
                        idle: if (start) fsm_d = expand;
                        expand: if (key_ack) fsm_d = init_add;
                        init_add: fsm_d = run_rounds;
                        run_rounds: if (round_cnt == '0) fsm_d = finish;
                        finish: fsm_d = key_ack ? key_release : idle;
                        key_release: if (!key_ack) fsm_d = idle; // Wait for the link to settle
                        default: fsm_d = idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        fsm_q <= idle;
                        key_req <= 1'b0;
                        round_cnt <= '0;
                end else begin
                        fsm_q <= fsm_d;
                        if (fsm_q == idle && start)
                                key_req <= 1'b1;
                        else if (fsm_q == expand && key_ack)
                                key_req <= 1'b0;
                        if (fsm_q == init_add)
                                round_cnt <= aes_types_pkg::round_idx_t'(ROUNDS - 1);
                        else if (fsm_q == run_rounds)
                                round_cnt <= round_cnt - 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                case (fsm_q)
                        idle: begin
                                if (start) begin
                                        state_q <= job.cipher_text;
                                        cipher_key <= job.cipher_key; // Stable for the whole request
                                end
                        end
                        init_add: state_q <= state_q ^ round_key;
                        run_rounds: state_q <= next_state;
                        default: state_q <= state_q;
                endcase
        end

        assign key_sel = (fsm_q == init_add) ? aes_types_pkg::round_idx_t'(ROUNDS) : round_cnt;
        assign mix_enable = (round_cnt != '0);
        assign round_state = state_q;
        assign plain_text = state_q; // Kept until the next job is taken
        assign done = (fsm_q == finish);

endmodule

// ==== source/aes_inv_cipher.sv ====
module aes_inv_cipher #(
        parameter int ROUNDS = aes_types_pkg::rounds_default
) (
        input logic clk,
        input logic rst,
        input logic start,
        input aes_types_pkg::inv_job_t job,
        output logic done,
        output aes_types_pkg::block_t plain_text
);

        logic key_req;
        logic key_ack;
        logic mix_enable;
        aes_types_pkg::block_t cipher_key;
        aes_types_pkg::block_t round_key;
        aes_types_pkg::block_t round_state;
        aes_types_pkg::block_t next_state;
        aes_types_pkg::round_idx_t key_sel;

        key_expander #(
                .ROUNDS(ROUNDS)
        ) i_key_expander (
                .clk(clk),
                .rst(rst),
                .key_req(key_req),
                .cipher_key(cipher_key),
                .key_ack(key_ack),
                .key_sel(key_sel),
                .round_key(round_key)
        );

        inv_round i_inv_round (
                .state_in(round_state),
                .round_key(round_key),
                .mix_enable(mix_enable),
                .state_out(next_state)
        );

        inv_cipher_ctrl #(
                .ROUNDS(ROUNDS)
        ) i_ctrl (
                .clk(clk),
                .rst(rst),
                .start(start),
                .job(job),
                .done(done),
                .plain_text(plain_text),
                .key_req(key_req),
                .cipher_key(cipher_key),
                .key_ack(key_ack),
                .key_sel(key_sel),
                .round_key(round_key),
                .round_state(round_state),
                .mix_enable(mix_enable),
                .next_state(next_state)
        );

endmodule

// ==== bench/clock_gen.sv ====
module clock_gen (
        output logic clk,
        output logic rst
);

        timeunit 1ns;
        timeprecision 1ps;

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk; // 100 ns period
        end

        initial begin
                rst = 1'b1;
                repeat (16) @(posedge clk);
                #10 rst = 1'b0; // Released with the other inputs
        end

endmodule

// ==== bench/aes_inv_chk.sv ====
module aes_inv_chk (
        input logic clk,
        input logic rst,
        input logic done,
        input logic key_req,
        input logic key_ack
);

        timeunit 1ns;
        timeprecision 1ps;

        int failures = 0;

        // One cycle pulse only
        done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
                else begin
                        $error("done stayed high for two cycles");
                        failures++;
                end

        req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
                key_req && !key_ack |=> key_req)
                else begin
                        $error("key_req dropped before key_ack rose");
                        failures++;
                end

        ack_held_until_release: assert property (@(posedge clk) disable iff (rst)
                key_ack && key_req |=> key_ack)
                else begin
                        $error("key_ack dropped while key_req was still high");
                        failures++;
                end

        done_low_after_reset: assert property (@(posedge clk) rst |=> !done)
                else begin
                        $error("done high in the cycle after reset");
                        failures++;
                end

endmodule

bind inv_cipher_ctrl aes_inv_chk i_chk (
        .clk(clk),
        .rst(rst),
        .done(done),
        .key_req(key_req),
        .key_ack(key_ack)
);

// ==== bench/aes_inv_tb.sv ====
module aes_inv_tb;

        timeunit 1ns;
        timeprecision 1ps;

        // 14 jobs of at most 40 cycles plus gaps, reset and idle watches
        localparam int timeout_cycles = 2000;
        localparam int job_cycle_bound = 40;

        localparam aes_types_pkg::block_t key_c1 = 128'h000102030405060708090a0b0c0d0e0f;
        localparam aes_types_pkg::block_t ct_c1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        localparam aes_types_pkg::block_t pt_c1 = 128'h00112233445566778899aabbccddeeff;
        localparam aes_types_pkg::block_t key_b = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        localparam aes_types_pkg::block_t ct_b = 128'h3925841d02dc09fbdc118597196a0b32;
        localparam aes_types_pkg::block_t pt_b = 128'h3243f6a8885a308d313198a2e0370734;

        logic clk;
        logic rst;
        logic start;
        logic done;
        aes_types_pkg::inv_job_t job;
        aes_types_pkg::block_t plain_text;
        logic [15:0] lfsr_state;
        int errors;
        int checks;
        int cycle_count;

        clock_gen i_clock_gen (
                .clk(clk),
                .rst(rst)
        );

        aes_inv_cipher #(
                .ROUNDS(aes_types_pkg::rounds_default)
        ) i_dut (
                .clk(clk),
                .rst(rst),
                .start(start),
                .job(job),
                .done(done),
                .plain_text(plain_text)
        );

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        task automatic draw_gap(output int gap);
                gap = 0;
                for (int b = 0; b < 3; b++) begin
                        gap = (gap << 1) | lfsr_state[15];
                        lfsr_state = lfsr_next(lfsr_state);
                end
        endtask

        task automatic expect_block(input string what, input aes_types_pkg::block_t got,
                                    input aes_types_pkg::block_t want);
                checks++;
                assert (got === want)
                else begin
                        $display("ERROR at %0d ns: %s: got %h, expected %h",
                                 $time, what, got, want);
                        errors++;
                end
        endtask

        task automatic expect_low(input string what, input logic value);
                checks++;
                assert (value === 1'b0)
                else begin
                        $display("ERROR at %0d ns: %s: got %b, expected 0",
                                 $time, what, value);
                        errors++;
                end
        endtask

        task automatic report_test(input string name, input int errors_at_start);
                $display("%-22s finished with %0d error(s)", name, errors - errors_at_start);
        endtask

        task automatic wait_for_done(output bit seen);
                int waited;
                seen = 1'b0;
                waited = 0;
                while (!seen && waited < job_cycle_bound) begin
                        @(negedge clk);
                        waited++;
                        if (done === 1'b1)
                                seen = 1'b1;
                end
                if (!seen) begin
                        $display("Job gave no done pulse within %0d cycles", job_cycle_bound);
                        errors++;
                end
        endtask

        // Start one job, then check result and pulse width
        task automatic run_job(input string name, input aes_types_pkg::block_t key,
                               input aes_types_pkg::block_t ct, input aes_types_pkg::block_t pt);
                bit seen;
                @(posedge clk);
                #10;
                start = 1'b1;
                job = '{cipher_text: ct, cipher_key: key};
                @(posedge clk);
                #10;
                start = 1'b0;
                wait_for_done(seen);
                if (seen) begin
                        expect_block(name, plain_text, pt);
                        @(negedge clk);
                        expect_low("done one cycle after pulse", done);
                end
        endtask

        task automatic quiet_after_reset();
                int first_error;
                first_error = errors;
                repeat (20) begin
                        @(negedge clk);
                        expect_low("done while idle after reset", done);
                end
                report_test("quiet_after_reset", first_error);
        endtask

        task automatic decrypt_c1_vector();
                int first_error;
                first_error = errors;
                run_job("C.1 plaintext", key_c1, ct_c1, pt_c1);
                report_test("decrypt_c1_vector", first_error);
        endtask

        task automatic rekey_b_then_c1();
                int first_error;
                first_error = errors;
                run_job("B plaintext", key_b, ct_b, pt_b);
                run_job("C.1 plaintext after B", key_c1, ct_c1, pt_c1);
                report_test("rekey_b_then_c1", first_error);
        endtask

        // Second job sits on the port while the first one runs
        task automatic busy_start_ignored();
                int first_error;
                int done_count;
                aes_types_pkg::block_t result;
                first_error = errors;
                done_count = 0;
                result = '0;
                @(posedge clk);
                #10;
                start = 1'b1;
                job = '{cipher_text: ct_b, cipher_key: key_b};
                @(posedge clk);
                #10;
                job = '{cipher_text: ct_c1, cipher_key: key_c1};
                for (int i = 0; i < 60; i++) begin
                        @(negedge clk);
                        if (done === 1'b1) begin
                                done_count++;
                                result = plain_text;
                        end
                        @(posedge clk);
                        #10;
                        if (i == 7)
                                start = 1'b0;
                end
                checks++;
                assert (done_count == 1)
                else begin
                        $display("ERROR at %0d ns: done pulses for one start: got %0d, expected 1",
                                 $time, done_count);
                        errors++;
                end
                expect_block("result with start held", result, pt_b);
                expect_block("result after start dropped", plain_text, pt_b);
                report_test("busy_start_ignored", first_error);
        endtask

        task automatic held_result_series();
                int first_error;
                int gap;
                aes_types_pkg::block_t want;
                first_error = errors;
                for (int n = 0; n < 10; n++) begin
                        if (n % 2 == 0) begin
                                run_job("series B plaintext", key_b, ct_b, pt_b);
                                want = pt_b;
                        end else begin
                                run_job("series C.1 plaintext", key_c1, ct_c1, pt_c1);
                                want = pt_c1;
                        end
                        draw_gap(gap);
                        repeat (gap) begin
                                @(negedge clk);
                                expect_block("result held while idle", plain_text, want);
                        end
                end
                report_test("held_result_series", first_error);
        endtask

        initial begin
                cycle_count = 0;
                while (cycle_count < timeout_cycles) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("Run stopped: still busy after %0d cycles", timeout_cycles);
                $display("Something failed");
                $finish;
        end

        initial begin
                start = 1'b0;
                job = '0;
                errors = 0;
                checks = 0;
                lfsr_state = 16'd3950;
                wait (rst === 1'b0);
                quiet_after_reset();
                decrypt_c1_vector();
                rekey_b_then_c1();
                busy_start_ignored();
                held_result_series();
                $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                         checks, errors, i_dut.i_ctrl.i_chk.failures);
                if (errors == 0 && i_dut.i_ctrl.i_chk.failures == 0)
                        $display("Everything OK");
                else
                        $display("Something failed");
                $finish;
        end

endmodule

// ==== aes_inv.f ====
source/aes_types_pkg.sv
source/aes_field_pkg.sv
source/byte_substitute.sv
source/key_expander.sv
source/inv_round.sv
source/inv_cipher_ctrl.sv
source/aes_inv_cipher.sv
bench/clock_gen.sv
bench/aes_inv_chk.sv
bench/aes_inv_tb.sv

// ==== Bender.yml ====
package:
  name: aes_inv

sources:
  - source/aes_types_pkg.sv
  - source/aes_field_pkg.sv
  - source/byte_substitute.sv
  - source/key_expander.sv
  - source/inv_round.sv
  - source/inv_cipher_ctrl.sv
  - source/aes_inv_cipher.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/aes_inv_chk.sv
      - bench/aes_inv_tb.sv
